//--- vlog.f
+incdir+src
src/rename_pkg.sv
src/free_list_bank.sv
src/reg_free_list.sv
sim/reg_free_list_assert.sv
sim/tb_reg_free_list.sv

//--- Makefile
# Verilator build, run and lint for the register free list

VERILATOR ?= verilator
TOP       := tb_reg_free_list
RTL_TOP   := reg_free_list
FILELIST  := vlog.f
RTL_SRCS  := src/rename_pkg.sv src/free_list_bank.sv src/reg_free_list.sv
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the simulator output
run: build
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) +incdir+src $(RTL_SRCS)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_reg_free_list.sv
// Free list testbench: directed table, per-bank queue model, LFSR soak, compare tasks, watchdog
`timescale 1ns/1ps
`include "rename_settings.svh"

module tb_reg_free_list;

	import rename_pkg::*;

	localparam int NB           = `RN_NBANKS;
	localparam int NP           = `RN_NPREGS;
	localparam int DEPTH        = `RN_BANK_DEPTH;
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int SOAK_CYCLES  = 400;

	typedef free_req_t [NB-1:0] lane_free_t;
	typedef preg_t [NB-1:0] lane_tag_t;

	localparam lane_free_t      NO_FREE  = '0;
	localparam lane_tag_t       NO_TAGS  = '0;
	localparam logic [NP-1:0]   NO_FLUSH = '0;

	// One directed step, held for reps cycles
	typedef struct {
		logic          en;
		logic [NB-1:0] alloc;
		lane_free_t    free;
		logic [NP-1:0] flush;
		int            reps;
		logic          exp_stall;
		logic          has_tags;
		lane_tag_t     tags;
		logic          chk_full;
	} row_t;

	logic          clk = 1'b0;
	logic          rst;
	logic          en;
	logic [NP-1:0] flush_mask;
	lane_free_t    free_req;
	logic [NB-1:0] alloc;
	lane_tag_t     alloc_tag;
	logic [NP-1:0] avail;
	logic          stall;

	row_t rows[$];

	// ========================================
	// Reference model state
	// ========================================

	// Bank FIFO contents in queue order, plus pending and available tags
	preg_t         model_q [NB][$];
	logic [NP-1:0] model_pend;
	logic [NP-1:0] model_avail;
	// Combinational view of the current cycle
	logic          m_stall;
	lane_tag_t     m_tag;
	// Tags handed out and not yet retired, per bank
	preg_t         outst [NB][$];
	logic [15:0]   lfsr_state;

	reg_free_list u_reg_free_list (
		.clk        (clk),
		.rst        (rst),
		.en         (en),
		.flush_mask (flush_mask),
		.free_req   (free_req),
		.alloc      (alloc),
		.alloc_tag  (alloc_tag),
		.avail      (avail),
		.stall      (stall)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_tag(input int lane, input preg_t got, input preg_t exp);
		if (got !== exp) begin
			$display("[FAIL] alloc_tag[%0d] got 0x%h expected 0x%h", lane, got, exp);
			abort_run();
		end
	endtask

	task automatic check_stall(input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] stall got 0x%h expected 0x%h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_avail(input logic [NP-1:0] got, input logic [NP-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] avail got 0x%h expected 0x%h", got, exp);
			abort_run();
		end
	endtask

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [15:0] draw_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Stall and new tags as the bank rules give them for this cycle
	function automatic void predict(input logic [NB-1:0] al, input lane_free_t fr);
		m_stall = 1'b0;
		for (int b = 0; b < NB; b++) begin
			if (fr[b].valid) begin
				m_tag[b] = fr[b].tag;
			end else if (model_q[b].size() > 0) begin
				m_tag[b] = model_q[b][0];
			end else begin
				m_tag[b] = '0;
				if (al[b]) begin
					m_stall = 1'b1;
				end
			end
		end
	endfunction

	// Applies the edge: pop or bypass, direct push, otherwise lowest pending reload
	function automatic void advance(input logic en_v, input logic [NB-1:0] al,
			input lane_free_t fr, input logic [NP-1:0] fl);
		logic          take;
		logic          pushed;
		logic [NP-1:0] taken;
		preg_t         t;
		if (!en_v) begin
			return;
		end
		taken = '0;
		for (int b = 0; b < NB; b++) begin
			take = al[b] && !m_stall;
			pushed = 1'b0;
			if (take && !fr[b].valid) begin
				t = model_q[b].pop_front();
				model_avail[t] = 1'b0;
			end else if (fr[b].valid && !take) begin
				model_q[b].push_back(fr[b].tag);
				model_avail[fr[b].tag] = 1'b1;
				pushed = 1'b1;
			end
			for (int j = 0; j < DEPTH; j++) begin
				if (!pushed && model_q[b].size() < DEPTH && model_pend[b * DEPTH + j]) begin
					t = preg_t'(b * DEPTH + j);
					model_q[b].push_back(t);
					model_avail[t] = 1'b1;
					taken[b * DEPTH + j] = 1'b1;
					pushed = 1'b1;
				end
			end
		end
		model_pend = (model_pend | fl) & ~taken;
	endfunction

	// Drive on the rising edge, check at the falling edge, then step the model
	task automatic apply_cycle(input logic en_v, input logic [NB-1:0] al,
			input lane_free_t fr, input logic [NP-1:0] fl);
		@(posedge clk);
		en         <= en_v;
		alloc      <= al;
		free_req   <= fr;
		flush_mask <= fl;
		@(negedge clk);
		predict(al, fr);
		check_stall(stall, m_stall);
		for (int b = 0; b < NB; b++) begin
			if (en_v && !m_stall && al[b]) begin
				check_tag(b, alloc_tag[b], m_tag[b]);
			end
		end
		check_avail(avail, model_avail);
		advance(en_v, al, fr, fl);
	endtask

	function automatic lane_tag_t tags4(input preg_t t0, input preg_t t1,
			input preg_t t2, input preg_t t3);
		return {t3, t2, t1, t0};
	endfunction

	function automatic lane_free_t frees(input logic [NB-1:0] mask, input lane_tag_t tg);
		lane_free_t f;
		f = '0;
		for (int b = 0; b < NB; b++) begin
			f[b].valid = mask[b];
			f[b].tag   = mask[b] ? tg[b] : '0;
		end
		return f;
	endfunction

	function automatic void add_row(input logic en_v, input logic [NB-1:0] al,
			input lane_free_t fr, input logic [NP-1:0] fl, input int reps, input logic st,
			input logic ht, input lane_tag_t tg, input logic full);
		row_t r;
		r.en = en_v;
		r.alloc = al;
		r.free = fr;
		r.flush = fl;
		r.reps = reps;
		r.exp_stall = st;
		r.has_tags = ht;
		r.tags = tg;
		r.chk_full = full;
		rows.push_back(r);
	endfunction

	// ========================================
	// Directed table
	// ========================================

	task automatic build_table();
		logic [NP-1:0] fl;
		// Lane 0 waits on an empty bank, then the banks fill from the reset reload
		add_row(1'b1, 4'b0001, NO_FREE, NO_FLUSH, 1, 1'b1, 1'b0, NO_TAGS, 1'b0);
		add_row(1'b1, 4'b0000, NO_FREE, NO_FLUSH, 63, 1'b0, 1'b0, NO_TAGS, 1'b0);
		// With en low nothing moves, and every tag is available
		add_row(1'b0, 4'b1111, NO_FREE, NO_FLUSH, 2, 1'b0, 1'b0, NO_TAGS, 1'b1);
		add_row(1'b1, 4'b1111, NO_FREE, NO_FLUSH, 1, 1'b0, 1'b1,
			tags4(8'd0, 8'd64, 8'd128, 8'd192), 1'b0);
		add_row(1'b1, 4'b1111, NO_FREE, NO_FLUSH, 3, 1'b0, 1'b0, NO_TAGS, 1'b0);
		// Same-bank free and allocation hand the freed tag straight back
		add_row(1'b1, 4'b1111, frees(4'b1111, tags4(8'd0, 8'd64, 8'd128, 8'd192)), NO_FLUSH,
			1, 1'b0, 1'b1, tags4(8'd0, 8'd64, 8'd128, 8'd192), 1'b0);
		// Freed tag goes behind the 60 already queued
		add_row(1'b1, 4'b0000, frees(4'b1111, tags4(8'd1, 8'd65, 8'd129, 8'd193)), NO_FLUSH,
			1, 1'b0, 1'b0, NO_TAGS, 1'b0);
		add_row(1'b1, 4'b1111, NO_FREE, NO_FLUSH, 60, 1'b0, 1'b0, NO_TAGS, 1'b0);
		add_row(1'b1, 4'b1111, NO_FREE, NO_FLUSH, 1, 1'b0, 1'b1,
			tags4(8'd1, 8'd65, 8'd129, 8'd193), 1'b0);
		// Bank 0 stays drained, so its lane holds the whole group
		add_row(1'b1, 4'b0000, frees(4'b1110, tags4(8'd0, 8'd69, 8'd133, 8'd197)), NO_FLUSH,
			1, 1'b0, 1'b0, NO_TAGS, 1'b0);
		add_row(1'b1, 4'b1111, NO_FREE, NO_FLUSH, 2, 1'b1, 1'b0, NO_TAGS, 1'b0);
		add_row(1'b1, 4'b1110, NO_FREE, NO_FLUSH, 1, 1'b0, 1'b1,
			tags4(8'd0, 8'd69, 8'd133, 8'd197), 1'b0);
		add_row(1'b1, 4'b0001, frees(4'b0001, tags4(8'd7, 8'd0, 8'd0, 8'd0)), NO_FLUSH,
			1, 1'b0, 1'b1, tags4(8'd7, 8'd0, 8'd0, 8'd0), 1'b0);
		// Flushed tags reload lowest first in each bank
		fl = '0;
		fl[40] = 1'b1;
		fl[3] = 1'b1;
		fl[10] = 1'b1;
		fl[130] = 1'b1;
		fl[129] = 1'b1;
		fl[255] = 1'b1;
		add_row(1'b1, 4'b0000, NO_FREE, fl, 1, 1'b0, 1'b0, NO_TAGS, 1'b0);
		add_row(1'b1, 4'b0000, NO_FREE, NO_FLUSH, 4, 1'b0, 1'b0, NO_TAGS, 1'b0);
		add_row(1'b1, 4'b1101, NO_FREE, NO_FLUSH, 1, 1'b0, 1'b1,
			tags4(8'd3, 8'd0, 8'd129, 8'd255), 1'b0);
		add_row(1'b1, 4'b0101, NO_FREE, NO_FLUSH, 1, 1'b0, 1'b1,
			tags4(8'd10, 8'd0, 8'd130, 8'd0), 1'b0);
		add_row(1'b1, 4'b0001, NO_FREE, NO_FLUSH, 1, 1'b0, 1'b1,
			tags4(8'd40, 8'd0, 8'd0, 8'd0), 1'b0);
	endtask

	task automatic run_table();
		row_t r;
		foreach (rows[i]) begin
			r = rows[i];
			for (int k = 0; k < r.reps; k++) begin
				apply_cycle(r.en, r.alloc, r.free, r.flush);
				check_stall(stall, r.exp_stall);
				for (int b = 0; b < NB; b++) begin
					if (r.has_tags && r.alloc[b]) begin
						check_tag(b, alloc_tag[b], r.tags[b]);
					end
				end
				if (r.chk_full && k == 0) begin
					check_avail(avail, '1);
				end
			end
		end
	endtask

	// ========================================
	// Random soak
	// ========================================

	task automatic run_soak();
		logic          en_v;
		logic [NB-1:0] al;
		lane_free_t    fr;
		int            pick [NB];
		logic [15:0]   bits;
		// Every tag neither queued nor pending is out in the pipeline
		for (int t = 0; t < NP; t++) begin
			if (!model_avail[t] && !model_pend[t]) begin
				outst[t / DEPTH].push_back(preg_t'(t));
			end
		end
		for (int c = 0; c < SOAK_CYCLES; c++) begin
			bits = draw_bits(3);
			en_v = (bits != 16'd0);
			bits = draw_bits(NB);
			al = bits[NB-1:0];
			fr = '0;
			for (int b = 0; b < NB; b++) begin
				pick[b] = -1;
				bits = draw_bits(2);
				if (bits[1:0] == 2'b11 && outst[b].size() > 0) begin
					bits = draw_bits(6);
					pick[b] = int'(bits) % outst[b].size();
					fr[b].valid = 1'b1;
					fr[b].tag = outst[b][pick[b]];
				end
			end
			apply_cycle(en_v, al, fr, NO_FLUSH);
			for (int b = 0; b < NB; b++) begin
				if (en_v && pick[b] >= 0) begin
					outst[b].delete(pick[b]);
				end
				if (en_v && !m_stall && al[b]) begin
					outst[b].push_back(m_tag[b]);
				end
			end
		end
	endtask

	initial begin
		int wd_cycles;
		rst = 1'b1;
		en = 1'b0;
		alloc = '0;
		free_req = '0;
		flush_mask = '0;
		model_pend = '1;
		model_avail = '0;
		lfsr_state = 16'd12100;
		build_table();
		wd_cycles = RESET_CYCLES + SOAK_CYCLES + 100;
		foreach (rows[i]) begin
			wd_cycles += rows[i].reps;
		end
		fork
			begin
				#(wd_cycles * CLK_PERIOD);
				$display("Watchdog expired before the test sequence finished");
				abort_run();
			end
		join_none
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		run_table();
		run_soak();
		@(posedge clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- sim/reg_free_list_assert.sv
// Free list assertions: FIFO level bound, caller free rules, distinct tags, state after reset
`timescale 1ns/1ps
`include "rename_settings.svh"

module reg_free_list_assert (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic                                     en,
	input  logic                                     stall,
	input  logic [`RN_NBANKS-1:0]                    alloc,
	input  rename_pkg::free_req_t [`RN_NBANKS-1:0]   free_req,
	input  rename_pkg::preg_t [`RN_NBANKS-1:0]       alloc_tag,
	input  logic [`RN_NPREGS-1:0]                    avail,
	input  rename_pkg::bank_cnt_t [`RN_NBANKS-1:0]   bank_cnt
);

	import rename_pkg::*;

	localparam int NBANKS = `RN_NBANKS;

	// Valid bits of the four lane frees, gathered for the reset check
	logic [NBANKS-1:0] free_valid;

	always_comb begin
		for (int b = 0; b < NBANKS; b++) begin
			free_valid[b] = free_req[b].valid;
		end
	end

	for (genvar b = 0; b < NBANKS; b++) begin : g_lane
		// A bank never queues more tags than it owns
		a_cnt_max: assert property (@(posedge clk) disable iff (rst)
			bank_cnt[b] <= CNT_W'(`RN_BANK_DEPTH))
			else $error("bank %0d FIFO count above its depth", b);

		// Lane b may only retire tags whose upper bits name bank b
		a_free_bank: assert property (@(posedge clk) disable iff (rst)
			(en && free_req[b].valid) |-> (free_req[b].tag[PREG_W-1:IDX_W] == SEL_W'(b)))
			else $error("lane %0d freed a tag of another bank", b);

		// A tag still sitting in a FIFO cannot be retiring at the same time
		a_free_busy: assert property (@(posedge clk) disable iff (rst)
			(en && free_req[b].valid) |-> !avail[free_req[b].tag])
			else $error("lane %0d freed a tag that is still available", b);

		for (genvar o = b + 1; o < NBANKS; o++) begin : g_pair
			// Two lanes renaming in the same group never share a tag
			a_distinct: assert property (@(posedge clk) disable iff (rst)
				(en && !stall && alloc[b] && alloc[o]) |-> (alloc_tag[b] != alloc_tag[o]))
				else $error("lanes %0d and %0d got the same tag", b, o);
		end
	end

	// Every bank leaves reset empty with nothing available
	// So only a lane that asks without returning a tag can raise stall
	a_reset_stall: assert property (@(posedge clk)
		$fell(rst) |-> (bank_cnt == '0 && avail == '0 &&
			stall == |(alloc & ~free_valid)))
		else $error("bank state or stall wrong in the first cycle after reset");

endmodule

bind reg_free_list reg_free_list_assert u_assert (
	.clk       (clk),
	.rst       (rst),
	.en        (en),
	.stall     (stall),
	.alloc     (alloc),
	.free_req  (free_req),
	.alloc_tag (alloc_tag),
	.avail     (avail),
	.bank_cnt  ({g_bank[3].u_bank.count, g_bank[2].u_bank.count,
	             g_bank[1].u_bank.count, g_bank[0].u_bank.count})
);

//--- src/reg_free_list.sv
// Register free list top: four tag banks, pending-reload mask, availability bitmap, group stall
`timescale 1ns/1ps
`include "rename_settings.svh"

module reg_free_list (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   en,
	input  logic [`RN_NPREGS-1:0]                  flush_mask,
	input  rename_pkg::free_req_t [`RN_NBANKS-1:0] free_req,
	input  logic [`RN_NBANKS-1:0]                  alloc,
	output rename_pkg::preg_t [`RN_NBANKS-1:0]     alloc_tag,
	output logic [`RN_NPREGS-1:0]                  avail,
	output logic                                   stall
);

	import rename_pkg::*;

	localparam int NPREGS = `RN_NPREGS;
	localparam int NBANKS = `RN_NBANKS;
	localparam int DEPTH  = `RN_BANK_DEPTH;

	// ========================================
	// Bank interconnect
	// ========================================

	// Tags still to be loaded into a bank FIFO
	// Bank b owns the slice [b*DEPTH +: DEPTH]
	logic [NPREGS-1:0] pend;

	// One-hot clears from each bank's reload scanner, assembled per slice
	logic [NPREGS-1:0] scan_take;

	// Per-bank stall requests, ORed into the group stall
	logic [NBANKS-1:0] stall_req;

	// Push and pop reports used to maintain avail
	logic  [NBANKS-1:0] push_valid;
	preg_t [NBANKS-1:0] push_tag;
	logic  [NBANKS-1:0] pop_valid;
	preg_t [NBANKS-1:0] pop_tag;

	// Allocation is accepted in all banks or in none
	logic grant;

	// ========================================
	// Group stall
	// ========================================

	// Any bank that cannot serve its lane holds back all four lanes, so
	// the rename group moves as one
	always_comb begin
		stall = |stall_req;
		grant = en & ~stall;
	end

	// ========================================
	// Banks
	// ========================================

	for (genvar b = 0; b < NBANKS; b++) begin : g_bank
		free_list_bank #(
			.BANK (b)
		) u_bank (
			.clk        (clk),
			.rst        (rst),
			.en         (en),
			.grant      (grant),
			.alloc      (alloc[b]),
			.free_req   (free_req[b]),
			.pend       (pend[b*DEPTH +: DEPTH]),
			.alloc_tag  (alloc_tag[b]),
			.stall_req  (stall_req[b]),
			.push_tag   (push_tag[b]),
			.push_valid (push_valid[b]),
			.scan_take  (scan_take[b*DEPTH +: DEPTH]),
			.pop_valid  (pop_valid[b]),
			.pop_tag    (pop_tag[b])
		);
	end

	// ========================================
	// Pending-reload mask
	// ========================================

	// Reset marks every tag as needing a reload, so the banks fill
	// themselves one tag per cycle each.
	// A flushed tag joins the mask at the edge; a tag being reloaded in
	// this cycle leaves it, even if it is flushed at the same time
	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= '1;
		end else if (en) begin
			pend <= (pend | flush_mask) & ~scan_take;
		end
	end

	// ========================================
	// Availability bitmap
	// ========================================

	// A bit is set exactly while its tag sits in some bank FIFO.
	// Bypassed frees never enter a FIFO, so they leave avail alone.
	// A push and a pop in one bank never name the same tag
	always_ff @(posedge clk) begin
		if (rst) begin
			avail <= '0;
		end else if (en) begin
			for (int b = 0; b < NBANKS; b++) begin
				if (pop_valid[b]) begin
					avail[pop_tag[b]] <= 1'b0;
				end
				if (push_valid[b]) begin
					avail[push_tag[b]] <= 1'b1;
				end
			end
		end
	end

endmodule

//--- src/free_list_bank.sv
// Free list bank: tag FIFO, pending-reload scanner, allocation bypass and stall request
`timescale 1ns/1ps
`include "rename_settings.svh"

module free_list_bank #(
	parameter int BANK = 0
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       en,
	input  logic                       grant,
	input  logic                       alloc,
	input  rename_pkg::free_req_t      free_req,
	input  logic [`RN_BANK_DEPTH-1:0]  pend,
	output rename_pkg::preg_t          alloc_tag,
	output logic                       stall_req,
	output rename_pkg::preg_t          push_tag,
	output logic                       push_valid,
	output logic [`RN_BANK_DEPTH-1:0]  scan_take,
	output logic                       pop_valid,
	output rename_pkg::preg_t          pop_tag
);

	import rename_pkg::*;

	localparam int DEPTH = `RN_BANK_DEPTH;

	// Builds a full tag from an offset by prefixing this bank's number
	function automatic preg_t mk_tag(input bank_idx_t off);
		preg_t t;
		t = {SEL_W'(BANK), off};
		return t;
	endfunction

	// ========================================
	// Tag FIFO storage and pointers
	// ========================================

	// Only offsets are stored, the bank number is implied
	bank_idx_t fifo_mem [DEPTH];

	bank_idx_t head;
	bank_idx_t tail;
	bank_cnt_t count;

	logic fifo_empty;
	logic fifo_full;

	// Offset waiting at the head of the FIFO, as a full tag
	preg_t head_tag;

	// Allocation handshake
	logic take;
	logic pop;
	logic direct_push;
	logic reload_push;

	// Reload scanner
	logic                  scan_valid;
	bank_idx_t             scan_off;
	logic [DEPTH-1:0]      scan_onehot;

	// Offset that goes into the FIFO this cycle
	bank_idx_t push_off;

	always_comb begin
		fifo_empty = (count == '0);
		fifo_full  = (count == CNT_W'(DEPTH));
		head_tag   = mk_tag(fifo_mem[head]);
	end

	// ========================================
	// Allocation and bypass
	// ========================================

	// A valid free in this bank is handed straight back as the new tag
	// The FIFO head is used only when nothing is being returned
	always_comb begin
		if (free_req.valid) begin
			alloc_tag = free_req.tag;
		end else begin
			alloc_tag = head_tag;
		end
	end

	// Nothing to give: an allocation is waiting, the FIFO is empty and no
	// tag is coming back on this lane
	always_comb begin
		stall_req = alloc & fifo_empty & ~free_req.valid;
	end

	// grant already folds in en and the group stall from the parent
	// A pop happens only when the head was actually used
	always_comb begin
		take = grant & alloc;
		pop  = take & ~free_req.valid;
	end

	// A free that is not consumed by the bypass goes to the tail
	always_comb begin
		direct_push = en & free_req.valid & ~take;
	end

	// ========================================
	// Reload scanner
	// ========================================

	// Lowest pending offset wins, so a flush reloads in ascending order
	always_comb begin
		scan_off = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (pend[i]) begin
				scan_off = bank_idx_t'(i);
			end
		end
	end

	// Isolates the lowest set bit of the pending slice
	always_comb begin
		scan_valid  = |pend;
		scan_onehot = pend & (~pend + 1'b1);
	end

	// The reload uses the write port only when no direct free needs it.
	// A slot freed by a pop in the same cycle counts as room
	always_comb begin
		reload_push = en & ~direct_push & scan_valid & (~fifo_full | pop);
	end

	always_comb begin
		if (direct_push) begin
			push_off = free_req.tag[IDX_W-1:0];
		end else begin
			push_off = scan_off;
		end
	end

	// ========================================
	// Reports to the parent
	// ========================================

	// Parent uses these to keep the availability bitmap in step
	always_comb begin
		push_valid = direct_push | reload_push;
		push_tag   = mk_tag(push_off);
		pop_valid  = pop;
		pop_tag    = head_tag;
	end

	// Clears the reloaded offset from the pending mask at the same edge
	always_comb begin
		if (reload_push) begin
			scan_take = scan_onehot;
		end else begin
			scan_take = '0;
		end
	end

	// ========================================
	// FIFO state update
	// ========================================

	// Pointers wrap naturally since the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push_valid) begin
				tail <= tail + 1'b1;
			end
			if (pop) begin
				head <= head + 1'b1;
			end
			// Push and pop together leave the level unchanged
			if (push_valid && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push_valid) begin
				count <= count - 1'b1;
			end
		end
	end

	// Storage holds no control state
	always_ff @(posedge clk) begin
		if (push_valid) begin
			fifo_mem[tail] <= push_off;
		end
	end

endmodule

//--- src/rename_pkg.sv
// Rename package: physical tag types, in-bank offset type and the lane free request struct
`include "rename_settings.svh"

package rename_pkg;

	// ========================================
	// Widths derived from the sizing macros
	// ========================================

	// Bits in a full physical tag
	localparam int PREG_W = $clog2(`RN_NPREGS);

	// Bits in a tag offset within one bank
	localparam int IDX_W = $clog2(`RN_BANK_DEPTH);

	// Upper tag bits that select the owning bank
	localparam int SEL_W = PREG_W - IDX_W;

	// A FIFO occupancy count has to reach the full depth, so one extra bit
	localparam int CNT_W = IDX_W + 1;

	// ========================================
	// Types
	// ========================================

	// Physical register tag as seen by the rename lanes
	typedef logic [PREG_W-1:0] preg_t;

	// Offset of a tag inside its bank
	// The bank number supplies the remaining upper bits
	typedef logic [IDX_W-1:0] bank_idx_t;

	// FIFO fill level of one bank
	typedef logic [CNT_W-1:0] bank_cnt_t;

	// A tag handed back by a lane at retire
	// Only tags of the lane's own bank may be returned here
	typedef struct packed {
		logic  valid;
		preg_t tag;
	} free_req_t;

endpackage

//--- src/rename_settings.svh
// Free list sizing macros: physical tag count, bank count and per-bank FIFO depth
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// ========================================
// Free list geometry
// ========================================

// Number of physical register tags held by the free list
`define RN_NPREGS 256

// Number of banks, one per rename lane
// Bank i owns the tags whose upper bits equal i
`define RN_NBANKS 4

// Tags owned by each bank, which is also the depth of its tag FIFO
// Must equal RN_NPREGS / RN_NBANKS and be a power of two
`define RN_BANK_DEPTH 64

`endif
